//--- verilog/ex_pkg.sv
package ex_pkg;

    // Width of a CSR address field
    localparam int unsigned CSR_ADDR_WIDTH = 12;

    // ------------------------------------------------------------
    // Operations of the fixed-latency units
    // ------------------------------------------------------------
    typedef enum logic [4:0] {
        // ALU
        ADD       = 5'd0,
        SUB       = 5'd1,
        XORL      = 5'd2,
        ORL       = 5'd3,
        ANDL      = 5'd4,
        SLL       = 5'd5,
        SRL       = 5'd6,
        SRA       = 5'd7,
        SLTS      = 5'd8,
        SLTU      = 5'd9,
        // Multiplier
        MUL       = 5'd16,
        MULH      = 5'd17,
        MULHU     = 5'd18,
        MULHSU    = 5'd19,
        // CSR access
        CSR_READ  = 5'd24,
        CSR_WRITE = 5'd25,
        CSR_SET   = 5'd26,
        CSR_CLEAR = 5'd27
    } fu_op_e;

endpackage

//--- verilog/fu_data_if.sv
`timescale 1ns/1ps

// Issued operation, shared by all fixed-latency units
interface fu_data_if #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
);

    ex_pkg::fu_op_e           operation;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;  // scoreboard entry to write back to

    modport issue (
        output operation,
        output operand_a,
        output operand_b,
        output trans_id
    );

    modport unit (
        input  operation,
        input  operand_a,
        input  operand_b,
        input  trans_id
    );

endinterface

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu import ex_pkg::*; #(
    parameter int unsigned XLEN = 64
) (
    fu_data_if.unit         fu_i,
    output logic [XLEN-1:0] result_o
);

    localparam int unsigned SHAMT_WIDTH = $clog2(XLEN);

    logic                   is_sub;
    logic [XLEN-1:0]        adder_b;
    logic [XLEN-1:0]        adder_result;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic [XLEN-1:0]        shift_left;
    logic [XLEN-1:0]        shift_right_logic;
    logic [XLEN-1:0]        shift_right_arith;
    logic                   less_signed;
    logic                   less_unsigned;

    // ------------------------------------------------------------
    // Adder
    // ------------------------------------------------------------
    // Subtraction as a + ~b + 1
    assign is_sub       = (fu_i.operation == SUB);
    assign adder_b      = is_sub ? ~fu_i.operand_b : fu_i.operand_b;
    assign adder_result = fu_i.operand_a + adder_b + XLEN'(is_sub);

    // ------------------------------------------------------------
    // Shifter
    // ------------------------------------------------------------
    // Only the low bits of operand b count
    assign shamt             = fu_i.operand_b[SHAMT_WIDTH-1:0];
    assign shift_left        = fu_i.operand_a << shamt;
    assign shift_right_logic = fu_i.operand_a >> shamt;
    assign shift_right_arith = $unsigned($signed(fu_i.operand_a) >>> shamt);

    // Comparisons
    assign less_signed   = $signed(fu_i.operand_a) < $signed(fu_i.operand_b);
    assign less_unsigned = fu_i.operand_a < fu_i.operand_b;

    // Result select
    always_comb begin
        case (fu_i.operation)
            ADD, SUB: begin
                result_o = adder_result;
            end
            XORL:     result_o = fu_i.operand_a ^ fu_i.operand_b;
            ORL:      result_o = fu_i.operand_a | fu_i.operand_b;
            ANDL:     result_o = fu_i.operand_a & fu_i.operand_b;
            SLL:      result_o = shift_left;
            SRL:      result_o = shift_right_logic;
            SRA:      result_o = shift_right_arith;
            // Set-less-than zero-extended to the full width
            SLTS: begin
                result_o = {{(XLEN-1){1'b0}}, less_signed};
            end
            SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, less_unsigned};
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- verilog/multiplier.sv
`timescale 1ns/1ps

module multiplier import ex_pkg::*; #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     mult_valid_i,
    fu_data_if.unit                  fu_i,
    output logic                     mult_valid_o,
    output logic [XLEN-1:0]          result_o,
    output logic [TRANS_ID_BITS-1:0] trans_id_o
);

    logic                     sign_a;
    logic                     sign_b;
    logic signed [XLEN:0]     operand_a_ext;
    logic signed [XLEN:0]     operand_b_ext;
    logic signed [2*XLEN+1:0] product;
    logic [XLEN-1:0]          result_d;
    logic                     mult_valid_q;
    logic [XLEN-1:0]          result_q;
    logic [TRANS_ID_BITS-1:0] trans_id_q;

    // ------------------------------------------------------------
    // Product
    // ------------------------------------------------------------
    // One extra bit per operand covers all signedness combinations
    assign sign_a = (fu_i.operation == MULH) || (fu_i.operation == MULHSU);
    assign sign_b = (fu_i.operation == MULH);

    assign operand_a_ext = $signed({sign_a & fu_i.operand_a[XLEN-1], fu_i.operand_a});
    assign operand_b_ext = $signed({sign_b & fu_i.operand_b[XLEN-1], fu_i.operand_b});
    assign product       = operand_a_ext * operand_b_ext;

    // MUL keeps the low half, the MULH variants the high half
    assign result_d = (fu_i.operation == MUL) ? product[XLEN-1:0]
                                              : product[2*XLEN-1:XLEN];

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mult_valid_q <= 1'b0;
        end else begin
            mult_valid_q <= mult_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mult_valid_i) begin
            result_q   <= result_d;
            trans_id_q <= fu_i.trans_id;
        end
    end

    // A flush also drops the result that is leaving this cycle
    assign mult_valid_o = mult_valid_q & ~flush_i;
    assign result_o     = result_q;
    assign trans_id_o   = trans_id_q;

    // Operands at issue must have been fully known
    a_result_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        mult_valid_o |-> !$isunknown(result_o)
    ) else $error("multiplier: unknown bits in result_o while valid");

endmodule

//--- verilog/csr_buffer.sv
`timescale 1ns/1ps

module csr_buffer import ex_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    input  logic                      csr_valid_i,
    input  logic                      csr_commit_i,
    fu_data_if.unit                   fu_i,
    output logic                      csr_ready_o,
    output logic [CSR_ADDR_WIDTH-1:0] csr_addr_o
);

    logic                      full_q;
    logic [CSR_ADDR_WIDTH-1:0] csr_addr_q;

    // ------------------------------------------------------------
    // Single entry
    // ------------------------------------------------------------
    // Address sits in operand b until the instruction commits
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            full_q     <= 1'b0;
            csr_addr_q <= '0;
        end else if (flush_i || csr_commit_i) begin
            full_q     <= 1'b0;
            csr_addr_q <= '0;
        end else if (csr_valid_i) begin
            full_q     <= 1'b1;
            csr_addr_q <= fu_i.operand_b[CSR_ADDR_WIDTH-1:0];
        end
    end

    // Full buffer blocks further issue
    assign csr_ready_o = ~full_q;
    assign csr_addr_o  = csr_addr_q;

    // ------------------------------------------------------------
    // Protocol checks
    // ------------------------------------------------------------
    // Issue logic has to respect ready
    a_no_issue_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> !full_q
    ) else $error("csr_buffer: CSR issued while the buffer is full");

    // Commit only for an instruction that was buffered
    a_no_commit_when_empty: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        csr_commit_i |-> full_q
    ) else $error("csr_buffer: commit while the buffer is empty");

endmodule

//--- verilog/flu_writeback.sv
`timescale 1ns/1ps

module flu_writeback import ex_pkg::*; #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                     alu_valid_i,
    input  logic                     csr_valid_i,
    fu_data_if.unit                  fu_i,
    input  logic [XLEN-1:0]          alu_result_i,
    input  logic                     mult_valid_i,
    input  logic [XLEN-1:0]          mult_result_i,
    input  logic [TRANS_ID_BITS-1:0] mult_trans_id_i,
    output logic [XLEN-1:0]          flu_result_o,
    output logic [TRANS_ID_BITS-1:0] flu_trans_id_o,
    output logic                     flu_valid_o
);

    logic [2:0] source_valid;

    assign source_valid = {alu_valid_i, csr_valid_i, mult_valid_i};
    assign flu_valid_o  = alu_valid_i | csr_valid_i | mult_valid_i;

    // ------------------------------------------------------------
    // Result mux
    // ------------------------------------------------------------
    always_comb begin
        flu_trans_id_o = fu_i.trans_id;
        if (alu_valid_i) begin
            flu_result_o = alu_result_i;
        end else if (csr_valid_i) begin
            // CSR value is returned as operand a
            flu_result_o = fu_i.operand_a;
        end else begin
            flu_result_o = mult_result_i;
            if (mult_valid_i) begin
                // Multiply belongs to the previous issue
                flu_trans_id_o = mult_trans_id_i;
            end
        end
    end

    // ------------------------------------------------------------
    // Port sharing checks
    // ------------------------------------------------------------
    // No ALU or CSR issue in the cycle a multiply result emerges
    a_single_source: assert final (
        $isunknown(source_valid) || $onehot0(source_valid)
    ) else $error("flu_writeback: more than one result source valid");

    // Strobe and operation must name the same unit
    a_op_matches_unit: assert final (
        (alu_valid_i !== 1'b1 ||
         fu_i.operation inside {ADD, SUB, XORL, ORL, ANDL, SLL, SRL, SRA, SLTS, SLTU}) &&
        (csr_valid_i !== 1'b1 ||
         fu_i.operation inside {CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR})
    ) else $error("flu_writeback: operation does not match the valid strobe");

endmodule

//--- verilog/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
    parameter int unsigned XLEN          = 64,
    parameter int unsigned TRANS_ID_BITS = 3
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_i,
    // Issue port
    input  fu_op_e                    operation_i,
    input  logic [XLEN-1:0]           operand_a_i,
    input  logic [XLEN-1:0]           operand_b_i,
    input  logic [TRANS_ID_BITS-1:0]  trans_id_i,
    input  logic                      alu_valid_i,
    input  logic                      mult_valid_i,
    input  logic                      csr_valid_i,
    input  logic                      csr_commit_i,
    // Write-back port
    output logic [XLEN-1:0]           flu_result_o,
    output logic [TRANS_ID_BITS-1:0]  flu_trans_id_o,
    output logic                      flu_valid_o,
    output logic                      flu_ready_o,
    output logic [CSR_ADDR_WIDTH-1:0] csr_addr_o
);

    logic [XLEN-1:0]          alu_result;
    logic                     mult_valid;
    logic [XLEN-1:0]          mult_result;
    logic [TRANS_ID_BITS-1:0] mult_trans_id;

    // ------------------------------------------------------------
    // Shared issue port
    // ------------------------------------------------------------
    fu_data_if #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) fu_data ();

    assign fu_data.operation = operation_i;
    assign fu_data.operand_a = operand_a_i;
    assign fu_data.operand_b = operand_b_i;
    assign fu_data.trans_id  = trans_id_i;

    // ------------------------------------------------------------
    // Fixed-latency units
    // ------------------------------------------------------------
    // Integer ops, same cycle
    alu #(
        .XLEN (XLEN)
    ) i_alu (
        .fu_i     (fu_data),
        .result_o (alu_result)
    );

    // One cycle of latency, fully pipelined
    multiplier #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) i_multiplier (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .mult_valid_i (mult_valid_i),
        .fu_i         (fu_data),
        .mult_valid_o (mult_valid),
        .result_o     (mult_result),
        .trans_id_o   (mult_trans_id)
    );

    // Stage ready comes only from the CSR buffer
    csr_buffer i_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .csr_valid_i  (csr_valid_i),
        .csr_commit_i (csr_commit_i),
        .fu_i         (fu_data),
        .csr_ready_o  (flu_ready_o),
        .csr_addr_o   (csr_addr_o)
    );

    // Single write-back port into the scoreboard
    flu_writeback #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) i_flu_writeback (
        .alu_valid_i     (alu_valid_i),
        .csr_valid_i     (csr_valid_i),
        .fu_i            (fu_data),
        .alu_result_i    (alu_result),
        .mult_valid_i    (mult_valid),
        .mult_result_i   (mult_result),
        .mult_trans_id_i (mult_trans_id),
        .flu_result_o    (flu_result_o),
        .flu_trans_id_o  (flu_trans_id_o),
        .flu_valid_o     (flu_valid_o)
    );

endmodule

//--- tests/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int unsigned XLEN           = 64;
    localparam int unsigned TRANS_ID_BITS  = 3;
    localparam int unsigned SHAMT_WIDTH    = $clog2(XLEN);
    localparam int unsigned TIMEOUT_CYCLES = 2000;
    localparam logic [XLEN-1:0] SIGN_BIT   = {1'b1, {(XLEN-1){1'b0}}};

    logic                      clk_i = 1'b0;
    logic                      rst_ni;
    logic                      flush_i;
    fu_op_e                    operation_i;
    logic [XLEN-1:0]           operand_a_i;
    logic [XLEN-1:0]           operand_b_i;
    logic [TRANS_ID_BITS-1:0]  trans_id_i;
    logic                      alu_valid_i;
    logic                      mult_valid_i;
    logic                      csr_valid_i;
    logic                      csr_commit_i;
    logic [XLEN-1:0]           flu_result_o;
    logic [TRANS_ID_BITS-1:0]  flu_trans_id_o;
    logic                      flu_valid_o;
    logic                      flu_ready_o;
    logic [CSR_ADDR_WIDTH-1:0] csr_addr_o;

    integer seed;
    int     value_errors = 0;
    int     other_errors = 0;
    int     cycle_count  = 0;

    fu_op_e alu_ops[10] = '{ADD, SUB, XORL, ORL, ANDL, SLL, SRL, SRA, SLTS, SLTU};
    fu_op_e mult_ops[4] = '{MUL, MULH, MULHU, MULHSU};

    // Reference state
    logic                      mult_pend_q;
    logic [XLEN-1:0]           exp_mult_q;
    logic [TRANS_ID_BITS-1:0]  exp_mult_id_q;
    logic                      csr_full_q;
    logic [CSR_ADDR_WIDTH-1:0] csr_addr_q;
    logic [XLEN-1:0]           exp_alu_result;
    logic                      exp_flu_valid;

    ex_stage #(
        .XLEN          (XLEN),
        .TRANS_ID_BITS (TRANS_ID_BITS)
    ) i_ex_stage (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .flush_i        (flush_i),
        .operation_i    (operation_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .trans_id_i     (trans_id_i),
        .alu_valid_i    (alu_valid_i),
        .mult_valid_i   (mult_valid_i),
        .csr_valid_i    (csr_valid_i),
        .csr_commit_i   (csr_commit_i),
        .flu_result_o   (flu_result_o),
        .flu_trans_id_o (flu_trans_id_o),
        .flu_valid_o    (flu_valid_o),
        .flu_ready_o    (flu_ready_o),
        .csr_addr_o     (csr_addr_o)
    );

    always #4 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------
    function automatic logic [XLEN-1:0] alu_ref(input fu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [SHAMT_WIDTH-1:0] shamt;
        logic [XLEN-1:0]        fill;
        shamt = b[SHAMT_WIDTH-1:0];
        // Sign fill for arithmetic right shift
        fill  = a[XLEN-1] ? ~({XLEN{1'b1}} >> shamt) : '0;
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            XORL:    return a ^ b;
            ORL:     return a | b;
            ANDL:    return a & b;
            SLL:     return a << shamt;
            SRL:     return a >> shamt;
            SRA:     return (a >> shamt) | fill;
            // Flipping the sign bits turns a signed compare into an unsigned one
            SLTS:    return {{(XLEN-1){1'b0}}, (a ^ SIGN_BIT) < (b ^ SIGN_BIT)};
            SLTU:    return {{(XLEN-1){1'b0}}, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] mult_ref(input fu_op_e op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] wide_a;
        logic [2*XLEN-1:0] wide_b;
        logic [2*XLEN-1:0] prod;
        // Extension to full product width, then a truncated multiply
        wide_a = (op == MULH || op == MULHSU) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        wide_b = (op == MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod   = wide_a * wide_b;
        return (op == MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    assign exp_alu_result = alu_ref(operation_i, operand_a_i, operand_b_i);
    assign exp_flu_valid  = alu_valid_i | csr_valid_i | (mult_pend_q & ~flush_i);

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mult_pend_q <= 1'b0;
            csr_full_q  <= 1'b0;
            csr_addr_q  <= '0;
        end else begin
            mult_pend_q <= mult_valid_i & ~flush_i;
            if (flush_i || csr_commit_i) begin
                csr_full_q <= 1'b0;
            end else if (csr_valid_i) begin
                csr_full_q <= 1'b1;
                csr_addr_q <= operand_b_i[CSR_ADDR_WIDTH-1:0];
            end
        end
    end

    always @(posedge clk_i) begin
        if (mult_valid_i) begin
            exp_mult_q    <= mult_ref(operation_i, operand_a_i, operand_b_i);
            exp_mult_id_q <= trans_id_i;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_reset_valid: assert property (@(posedge clk_i) $rose(rst_ni) |-> !flu_valid_o)
        else begin
            value_errors++;
            $display("FAILED flu_valid_o expected 0 actual %h", $sampled(flu_valid_o));
        end

    a_reset_ready: assert property (@(posedge clk_i) $rose(rst_ni) |-> flu_ready_o)
        else begin
            value_errors++;
            $display("FAILED flu_ready_o expected 1 actual %h", $sampled(flu_ready_o));
        end

    a_reset_addr: assert property (@(posedge clk_i) $rose(rst_ni) |-> csr_addr_o == '0)
        else begin
            value_errors++;
            $display("FAILED csr_addr_o expected 000 actual %h", $sampled(csr_addr_o));
        end

    a_alu_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alu_valid_i |-> flu_result_o == exp_alu_result)
        else begin
            value_errors++;
            $display("FAILED flu_result_o (ALU op %h) expected %h actual %h",
                     $sampled(operation_i), $sampled(exp_alu_result),
                     $sampled(flu_result_o));
        end

    a_issue_trans_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (alu_valid_i || csr_valid_i) |-> flu_trans_id_o == trans_id_i)
        else begin
            value_errors++;
            $display("FAILED flu_trans_id_o expected %h actual %h",
                     $sampled(trans_id_i), $sampled(flu_trans_id_o));
        end

    a_csr_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_valid_i |-> flu_result_o == operand_a_i)
        else begin
            value_errors++;
            $display("FAILED flu_result_o (CSR) expected %h actual %h",
                     $sampled(operand_a_i), $sampled(flu_result_o));
        end

    a_valid_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flu_valid_o == exp_flu_valid)
        else begin
            value_errors++;
            $display("FAILED flu_valid_o expected %h actual %h",
                     $sampled(exp_flu_valid), $sampled(flu_valid_o));
        end

    a_mult_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_pend_q && !flush_i) |-> flu_result_o == exp_mult_q)
        else begin
            value_errors++;
            $display("FAILED flu_result_o (multiply) expected %h actual %h",
                     $sampled(exp_mult_q), $sampled(flu_result_o));
        end

    a_mult_trans_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mult_pend_q && !flush_i) |-> flu_trans_id_o == exp_mult_id_q)
        else begin
            value_errors++;
            $display("FAILED flu_trans_id_o (multiply) expected %h actual %h",
                     $sampled(exp_mult_id_q), $sampled(flu_trans_id_o));
        end

    // Flushed multiply must never show up on the write-back port
    a_flush_drops_mult: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_i ##1 flush_i |-> !flu_valid_o ##1 !flu_valid_o)
        else begin
            other_errors++;
            $display("Flushed multiply still produced a valid write-back");
        end

    a_ready_rule: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flu_ready_o == !csr_full_q)
        else begin
            value_errors++;
            $display("FAILED flu_ready_o expected %h actual %h",
                     !$sampled(csr_full_q), $sampled(flu_ready_o));
        end

    a_csr_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_full_q |-> csr_addr_o == csr_addr_q)
        else begin
            value_errors++;
            $display("FAILED csr_addr_o expected %h actual %h",
                     $sampled(csr_addr_q), $sampled(csr_addr_o));
        end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    function automatic logic [XLEN-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic clear_strobes();
        alu_valid_i  <= 1'b0;
        mult_valid_i <= 1'b0;
        csr_valid_i  <= 1'b0;
        csr_commit_i <= 1'b0;
        flush_i      <= 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            clear_strobes();
        end
    endtask

    // Strobe picked from the unit that owns the operation
    task automatic issue_op(input fu_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        @(posedge clk_i);
        clear_strobes();
        operation_i <= op;
        operand_a_i <= a;
        operand_b_i <= b;
        trans_id_i  <= TRANS_ID_BITS'($random(seed));
        case (op)
            MUL, MULH, MULHU, MULHSU:                  mult_valid_i <= 1'b1;
            CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR:   csr_valid_i  <= 1'b1;
            default:                                   alu_valid_i  <= 1'b1;
        endcase
    endtask

    task automatic send_commit();
        @(posedge clk_i);
        clear_strobes();
        csr_commit_i <= 1'b1;
    endtask

    task automatic send_flush();
        @(posedge clk_i);
        clear_strobes();
        flush_i <= 1'b1;
    endtask

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            other_errors++;
            $display("Timeout: sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d value, %0d other", value_errors, other_errors);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        seed         = 36;
        rst_ni       = 1'b0;
        flush_i      = 1'b0;
        operation_i  = ADD;
        operand_a_i  = '0;
        operand_b_i  = '0;
        trans_id_i   = '0;
        alu_valid_i  = 1'b0;
        mult_valid_i = 1'b0;
        csr_valid_i  = 1'b0;
        csr_commit_i = 1'b0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Every ALU op, random operands plus equal negative operands
        foreach (alu_ops[i]) begin
            repeat (4) begin
                issue_op(alu_ops[i], random_word(), random_word());
            end
            issue_op(alu_ops[i], SIGN_BIT | 64'd1, SIGN_BIT | 64'd1);
        end
        idle(1);

        // Back-to-back multiplies, results overlap with new issues
        repeat (3) begin
            foreach (mult_ops[i]) begin
                issue_op(mult_ops[i], random_word(), random_word());
            end
        end
        issue_op(MULHSU, SIGN_BIT, {XLEN{1'b1}});
        idle(2);

        // Multiply dropped by flush
        issue_op(MUL, random_word(), random_word());
        send_flush();
        idle(2);

        // CSR released by commit, ALU keeps working meanwhile
        issue_op(CSR_WRITE, random_word(), random_word());
        idle(2);
        issue_op(ADD, random_word(), random_word());
        send_commit();
        idle(2);

        // CSR released by flush
        issue_op(CSR_SET, random_word(), random_word());
        idle(2);
        send_flush();
        idle(3);
        @(negedge clk_i);

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/ex_pkg.sv
verilog/fu_data_if.sv
verilog/alu.sv
verilog/multiplier.sv
verilog/csr_buffer.sv
verilog/flu_writeback.sv
verilog/ex_stage.sv
tests/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  # Package and interface first, then units, then the top level
  - verilog/ex_pkg.sv
  - verilog/fu_data_if.sv
  - verilog/alu.sv
  - verilog/multiplier.sv
  - verilog/csr_buffer.sv
  - verilog/flu_writeback.sv
  - verilog/ex_stage.sv
  - target: test
    files:
      - tests/tb_ex_stage.sv
